/* compile.f */
exec_pkg.sv
mc_if.sv
alu.sv
div_unit.sv
shift_unit.sv
executer.sv
exec_top.sv
tb_exec_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the execute stage testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_exec_top -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0

/* tb_exec_top.sv */
module tb_exec_top import exec_pkg::*; ();

    localparam int XLEN    = 32;
    localparam int SHW     = $clog2(XLEN);
    localparam int TIMEOUT = 200;
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            unknown;
        logic [4:0]      rd;
        logic            we;
    } expect_t;

    logic            clk;
    logic            rst_n_i;
    logic            run_i;
    logic            stall_i;
    alu_op_e         alu_op_i;
    div_op_e         div_op_i;
    shift_op_e       shift_op_i;
    logic            unsigned_i;
    logic [XLEN-1:0] a_i;
    logic [XLEN-1:0] b_i;
    logic [4:0]      rd_i;
    logic            reg_we_i;
    logic [XLEN-1:0] result_o;
    logic            unknown_op_o;
    logic [4:0]      rd_o;
    logic            reg_we_o;
    logic            done_o;
    logic            busy_o;

    logic [31:0]     lfsr;
    expect_t         exp_q[$];
    expect_t         head;        // operation that the next done_o belongs to.
    logic            head_valid;
    logic            pop_pending;
    logic            started;
    logic            fast_accept;
    logic            slow_accept;
    int              err_cnt;
    int              accept_cnt;
    int              done_cnt;

    exec_top #(.XLEN(XLEN)) u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .stall_i      (stall_i),
        .alu_op_i     (alu_op_i),
        .div_op_i     (div_op_i),
        .shift_op_i   (shift_op_i),
        .unsigned_i   (unsigned_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .rd_i         (rd_i),
        .reg_we_i     (reg_we_i),
        .result_o     (result_o),
        .unknown_op_o (unknown_op_o),
        .rd_o         (rd_o),
        .reg_we_o     (reg_we_o),
        .done_o       (done_o),
        .busy_o       (busy_o)
    );

    always #10 clk = ~clk;

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        !started |-> !done_o && !reg_we_o && !busy_o && !unknown_op_o)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t: outputs active before any accepted operation", $time);
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_o |-> head_valid && result_o == head.result && unknown_op_o == head.unknown)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t: result %h unknown %b, expected %h unknown %b (valid %b)", $time,
                     $sampled(result_o), $sampled(unknown_op_o), head.result, head.unknown,
                     head_valid);
        end

    a_dest: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_o |-> rd_o == head.rd && reg_we_o == head.we)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t: rd %0d we %b, expected rd %0d we %b", $time,
                     $sampled(rd_o), $sampled(reg_we_o), head.rd, head.we);
        end

    // single cycle operations finish on the very next edge.
    a_fast: assert property (@(posedge clk) disable iff (!rst_n_i)
        fast_accept |=> done_o && !busy_o)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t: single cycle operation without done one cycle later", $time);
        end

    a_slow: assert property (@(posedge clk) disable iff (!rst_n_i)
        slow_accept |=> busy_o && !done_o)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t: unit operation did not raise busy_o", $time);
        end

    a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_o |=> busy_o || done_o)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR %0t: busy_o dropped without done_o", $time);
        end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic expect_t expected_for(input alu_op_e aop, input div_op_e dop,
            input shift_op_e sop, input logic uns, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [4:0] rd, input logic we);
        expect_t                e;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        q;
        logic [XLEN-1:0]        r;
        logic [SHW-1:0]         amt;
        sa   = a;
        sb   = b;
        amt  = b[SHW-1:0];
        e    = '0;
        e.rd = rd;
        if (sop != SH_NOP) begin
            case (sop)
                SH_SLL:  e.result = a << amt;
                SH_SRL:  e.result = a >> amt;
                default: e.result = sa >>> amt;
            endcase
        end else if (dop == DIV_DIV || dop == DIV_REM) begin
            if (b == '0) begin
                q = '1;
                r = a;
            end else if (!uns && a == MIN_NEG && b == '1) begin
                q = MIN_NEG; // signed overflow wraps.
                r = '0;
            end else if (uns) begin
                q = a / b;
                r = a % b;
            end else begin
                q = sa / sb;
                r = sa % sb;
            end
            e.result = (dop == DIV_REM) ? r : q;
        end else if (dop != DIV_NOP) begin
            e.unknown = 1'b1;
        end else begin
            case (aop)
                ALU_ADD:  e.result = a + b;
                ALU_SUB:  e.result = a - b;
                ALU_AND:  e.result = a & b;
                ALU_OR:   e.result = a | b;
                ALU_XOR:  e.result = a ^ b;
                ALU_SLT:  e.result = {{(XLEN-1){1'b0}}, sa < sb};
                ALU_SLTU: e.result = {{(XLEN-1){1'b0}}, a < b};
                default:  e.unknown = 1'b1;
            endcase
        end
        e.we = we && !e.unknown;
        return e;
    endfunction

    // the done seen at one falling edge is checked on the rising edge after it.
    task automatic next_cycle();
        @(negedge clk);
        if (pop_pending && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        head_valid  = (exp_q.size() > 0);
        head        = head_valid ? exp_q[0] : '0;
        pop_pending = (done_o === 1'b1);
        if (pop_pending) begin
            done_cnt++;
        end
        fast_accept = 1'b0;
        slow_accept = 1'b0;
    endtask

    task automatic idle_cycle();
        logic [31:0] r;
        next_cycle();
        draw(32, r);
        run_i      = 1'b0;
        stall_i    = r[0];
        alu_op_i   = alu_op_e'(r[4:1]);
        div_op_i   = div_op_e'(r[6:5]);
        shift_op_i = shift_op_e'(r[8:7]);
        a_i        = r;
        b_i        = ~r;
        rd_i       = r[13:9];
        reg_we_i   = 1'b1;
    endtask

    task automatic gap();
        logic [31:0] r;
        draw(2, r);
        if (r[1:0] == 2'b00) begin
            idle_cycle();
        end
    endtask

    task automatic offer_op(input alu_op_e aop, input div_op_e dop, input shift_op_e sop,
            input logic uns, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [31:0] r;
        logic [31:0] s;
        logic        taken;
        logic        slow;
        int          tries;
        draw(6, r);
        taken = 1'b0;
        tries = 0;
        while (!taken && tries < TIMEOUT) begin
            next_cycle();
            draw(2, s);
            run_i      = 1'b1;
            stall_i    = (s[1:0] == 2'b00);
            alu_op_i   = aop;
            div_op_i   = dop;
            shift_op_i = sop;
            unsigned_i = uns;
            a_i        = a;
            b_i        = b;
            rd_i       = r[4:0];
            reg_we_i   = r[5];
            if (!stall_i && !busy_o) begin
                exp_q.push_back(expected_for(aop, dop, sop, uns, a, b, r[4:0], r[5]));
                slow        = (sop != SH_NOP) ? (b[SHW-1:0] != '0) :
                              (dop == DIV_DIV || dop == DIV_REM);
                fast_accept = !slow;
                slow_accept = slow;
                started     = 1'b1;
                taken       = 1'b1;
                accept_cnt++;
            end
            tries++;
        end
        if (!taken) begin
            err_cnt++;
            $display("timeout: operation was not accepted within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic drain();
        int tries;
        tries = 0;
        idle_cycle();
        while ((exp_q.size() > 0 || busy_o) && tries < TIMEOUT) begin
            idle_cycle();
            tries++;
        end
        if (exp_q.size() > 0) begin
            err_cnt++;
            $display("timeout: %0d operations never completed", exp_q.size());
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] x;
        logic [31:0] y;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        run_i       = 1'b0;
        stall_i     = 1'b0;
        alu_op_i    = ALU_ADD;
        div_op_i    = DIV_NOP;
        shift_op_i  = SH_NOP;
        unsigned_i  = 1'b0;
        a_i         = '0;
        b_i         = '0;
        rd_i        = '0;
        reg_we_i    = 1'b0;
        lfsr        = 32'hdb16;
        head        = '0;
        head_valid  = 1'b0;
        pop_pending = 1'b0;
        started     = 1'b0;
        fast_accept = 1'b0;
        slow_accept = 1'b0;
        err_cnt     = 0;
        accept_cnt  = 0;
        done_cnt    = 0;
        repeat (16) next_cycle();
        rst_n_i = 1'b1;
        repeat (8) idle_cycle(); // run_i stays low, so nothing may happen.
        for (int i = 0; i < 60; i++) begin
            draw(4, r);
            draw(32, x);
            draw(32, y);
            offer_op(alu_op_e'(r[3:0]), DIV_NOP, SH_NOP, 1'b0, x, y);
            gap();
        end
        // a shift outranks whatever alu and div codes come with it.
        for (int i = 0; i < 40; i++) begin
            draw(8, r);
            draw(32, x);
            draw(32, y);
            if (r[1:0] == 2'b00) begin
                r[1:0] = 2'b01;
            end
            if (i % 4 == 0) begin
                y[SHW-1:0] = '0;
            end
            offer_op(alu_op_e'(r[7:4]), div_op_e'(r[3:2]), shift_op_e'(r[1:0]), 1'b0, x, y);
            gap();
        end
        for (int i = 0; i < 40; i++) begin
            draw(7, r);
            draw(32, x);
            draw(32, y);
            // the corner operands always go to a real divide or remainder.
            if (i % 8 == 1) begin
                y      = '0;
                r[1:0] = {r[1], !r[1]};
            end
            if (i % 8 == 3) begin
                x      = MIN_NEG;
                y      = '1;
                r[1:0] = {r[1], !r[1]};
                r[2]   = 1'b0;
            end
            offer_op(alu_op_e'(r[6:3]), div_op_e'(r[1:0]), SH_NOP, r[2], x, y);
            gap();
        end
        drain();
        if (done_cnt != accept_cnt) begin
            err_cnt++;
            $display("ERR %0t: %0d done pulses for %0d accepted operations", $time,
                     done_cnt, accept_cnt);
        end
        $display("accepted %0d, completed %0d, errors %0d", accept_cnt, done_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* exec_top.sv */
module exec_top import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            run_i,
    input  logic            stall_i,
    input  alu_op_e         alu_op_i,
    input  div_op_e         div_op_i,
    input  shift_op_e       shift_op_i,
    input  logic            unsigned_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  logic [4:0]      rd_i,
    input  logic            reg_we_i,
    output logic [XLEN-1:0] result_o,
    output logic            unknown_op_o,
    output logic [4:0]      rd_o,
    output logic            reg_we_o,
    output logic            done_o,
    output logic            busy_o
);

    mc_if #(.XLEN(XLEN)) div_bus ();
    mc_if #(.XLEN(XLEN)) shift_bus ();

    executer #(.XLEN(XLEN)) u_executer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .stall_i      (stall_i),
        .alu_op_i     (alu_op_i),
        .div_op_i     (div_op_i),
        .shift_op_i   (shift_op_i),
        .unsigned_i   (unsigned_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .rd_i         (rd_i),
        .reg_we_i     (reg_we_i),
        .div_bus      (div_bus.master),
        .shift_bus    (shift_bus.master),
        .result_o     (result_o),
        .unknown_op_o (unknown_op_o),
        .rd_o         (rd_o),
        .reg_we_o     (reg_we_o),
        .done_o       (done_o),
        .busy_o       (busy_o)
    );

    div_unit #(.XLEN(XLEN)) u_div_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (div_bus.unit)
    );

    shift_unit #(.XLEN(XLEN)) u_shift_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (shift_bus.unit)
    );

endmodule

/* executer.sv */
module executer import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            run_i,
    input  logic            stall_i,
    input  alu_op_e         alu_op_i,
    input  div_op_e         div_op_i,
    input  shift_op_e       shift_op_i,
    input  logic            unsigned_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  logic [4:0]      rd_i,
    input  logic            reg_we_i,
    mc_if.master            div_bus,
    mc_if.master            shift_bus,
    output logic [XLEN-1:0] result_o,
    output logic            unknown_op_o,
    output logic [4:0]      rd_o,
    output logic            reg_we_o,
    output logic            done_o,
    output logic            busy_o
);

    localparam int SHW = $clog2(XLEN);

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_WAIT_DIV = 2'd1,
        ST_WAIT_SH  = 2'd2
    } state_e;

    state_e          state_q;
    logic            accept;
    logic            sh_sel;
    logic            div_sel;
    logic            div_known;
    logic            start_div;
    logic            start_sh;
    logic            imm_done;
    logic            imm_unknown;
    logic [XLEN-1:0] imm_result;
    logic            finish_div;
    logic            finish_sh;
    logic [XLEN-1:0] alu_result;
    logic            alu_unknown;
    logic            reg_we_q;

    alu #(.XLEN(XLEN)) u_alu (
        .op_i         (alu_op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .result_o     (alu_result),
        .unknown_op_o (alu_unknown)
    );

    assign busy_o = (state_q != ST_IDLE);
    assign accept = run_i && !stall_i && !busy_o;

    // a shift wins over a divide, a divide wins over the alu.
    assign sh_sel    = (shift_op_i != SH_NOP);
    assign div_sel   = !sh_sel && (div_op_i != DIV_NOP);
    assign div_known = (div_op_i == DIV_DIV) || (div_op_i == DIV_REM);

    assign start_sh  = accept && sh_sel && (b_i[SHW-1:0] != '0);
    assign start_div = accept && div_sel && div_known;
    assign imm_done  = accept && !start_sh && !start_div;

    // zero shifts pass a through, unknown divide codes finish at once.
    assign imm_unknown = sh_sel ? 1'b0 : (div_sel ? 1'b1 : alu_unknown);
    assign imm_result  = sh_sel ? a_i : (div_sel ? '0 : alu_result);

    // kick is still high in the first wait cycle, before the unit drops ready.
    assign finish_div = (state_q == ST_WAIT_DIV) && !div_bus.kick && div_bus.ready;
    assign finish_sh  = (state_q == ST_WAIT_SH) && !shift_bus.kick && shift_bus.ready;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q        <= ST_IDLE;
            done_o         <= 1'b0;
            reg_we_o       <= 1'b0;
            unknown_op_o   <= 1'b0;
            div_bus.kick   <= 1'b0;
            shift_bus.kick <= 1'b0;
        end else begin
            done_o         <= imm_done || finish_div || finish_sh;
            div_bus.kick   <= start_div;
            shift_bus.kick <= start_sh;
            if (start_div) begin
                state_q <= ST_WAIT_DIV;
            end else if (start_sh) begin
                state_q <= ST_WAIT_SH;
            end else if (finish_div || finish_sh) begin
                state_q <= ST_IDLE;
            end
            if (imm_done) begin
                unknown_op_o <= imm_unknown;
                reg_we_o     <= reg_we_i && !imm_unknown;
            end else if (start_div || start_sh) begin
                unknown_op_o <= 1'b0;
                reg_we_o     <= 1'b0; // no write while a unit works.
            end else if (finish_div || finish_sh) begin
                reg_we_o <= reg_we_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imm_done) begin
            result_o <= imm_result;
        end else if (finish_div) begin
            result_o <= div_bus.result;
        end else if (finish_sh) begin
            result_o <= shift_bus.result;
        end
        if (accept) begin
            rd_o <= rd_i;
        end
        if (start_div || start_sh) begin
            reg_we_q <= reg_we_i;
        end
        if (start_div) begin
            div_bus.a    <= a_i;
            div_bus.b    <= b_i;
            div_bus.mode <= {unsigned_i, div_op_i == DIV_REM};
        end
        if (start_sh) begin
            shift_bus.a    <= a_i;
            shift_bus.b    <= b_i;
            shift_bus.mode <= {shift_op_i == SH_SRA, shift_op_i == SH_SLL};
        end
    end

    // a second done in a row needs a new operation accepted in between.
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        (done_o && !accept) |=> !done_o);

    // while one unit is awaited the other one sits idle and ready.
    a_one_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_o |-> $onehot({state_q == ST_WAIT_DIV, state_q == ST_WAIT_SH}) &&
                   ((state_q == ST_WAIT_DIV) ? shift_bus.ready : div_bus.ready));

endmodule

/* shift_unit.sv */
module shift_unit import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input logic clk,
    input logic rst_n_i,
    mc_if.unit  bus
);

    localparam int SHW = $clog2(XLEN);

    logic            start;
    logic [XLEN-1:0] val_q;
    logic [SHW-1:0]  cnt_q;
    logic            arith_q;
    logic            left_q;

    assign start = bus.kick && bus.ready;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bus.ready <= 1'b1;
            cnt_q     <= '0;
        end else if (start) begin
            bus.ready <= 1'b0;
            cnt_q     <= bus.b[SHW-1:0];
        end else if (!bus.ready) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                bus.ready <= 1'b1;
            end
        end
    end

    // one bit position per cycle.
    always_ff @(posedge clk) begin
        if (start) begin
            val_q   <= bus.a;
            arith_q <= bus.mode[1];
            left_q  <= bus.mode[0];
        end else if (!bus.ready && cnt_q != '0) begin
            if (left_q) begin
                val_q <= {val_q[XLEN-2:0], 1'b0};
            end else begin
                val_q <= {arith_q && val_q[XLEN-1], val_q[XLEN-1:1]}; // sign fill for sra.
            end
        end
    end

    assign bus.result = val_q;

    a_count_down: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!bus.ready && cnt_q != '0) |=> (cnt_q == $past(cnt_q) - 1'b1));

endmodule

/* div_unit.sv */
module div_unit import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input logic clk,
    input logic rst_n_i,
    mc_if.unit  bus
);

    localparam int CW = $clog2(XLEN) + 1;

    logic            start;
    logic            neg_a;
    logic            neg_b;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN:0]   trial;
    logic            fits;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvs_q;
    logic [CW-1:0]   cnt_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            rem_sel_q;
    logic [XLEN-1:0] result_q;

    assign start = bus.kick && bus.ready;

    // mode[1] selects unsigned operands, mode[0] returns the remainder.
    assign neg_a = !bus.mode[1] && bus.a[XLEN-1];
    assign neg_b = !bus.mode[1] && bus.b[XLEN-1];
    assign abs_a = neg_a ? -bus.a : bus.a;
    assign abs_b = neg_b ? -bus.b : bus.b;

    // the dividend shifts out of quo_q into the partial remainder.
    assign trial = {rem_q, quo_q[XLEN-1]};
    assign fits  = trial >= {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bus.ready <= 1'b1;
            cnt_q     <= '0;
        end else if (start) begin
            bus.ready <= 1'b0;
            cnt_q     <= CW'(XLEN);
        end else if (!bus.ready) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                bus.ready <= 1'b1; // sign fix-up cycle.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= abs_a;
            rem_q     <= '0;
            dvs_q     <= abs_b;
            neg_quo_q <= (neg_a ^ neg_b) && (bus.b != '0); // keep all ones on zero divisor.
            neg_rem_q <= neg_a;
            rem_sel_q <= bus.mode[0];
        end else if (!bus.ready) begin
            if (cnt_q != '0) begin
                rem_q <= fits ? (trial[XLEN-1:0] - dvs_q) : trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], fits};
            end else if (rem_sel_q) begin
                result_q <= neg_rem_q ? -rem_q : rem_q;
            end else begin
                result_q <= neg_quo_q ? -quo_q : quo_q;
            end
        end
    end

    assign bus.result = result_q;

    // the sequencer may only start the divider when it has finished.
    a_kick_when_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        bus.kick |-> bus.ready);

endmodule

/* alu.sv */
module alu import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    output logic            unknown_op_o
);

    logic slt;
    logic sltu;

    assign slt  = $signed(a_i) < $signed(b_i);
    assign sltu = a_i < b_i;

    always_comb begin
        result_o     = '0;
        unknown_op_o = 1'b0;
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, slt};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, sltu};
            end
            default: begin
                unknown_op_o = 1'b1; // result stays zero.
            end
        endcase
    end

endmodule

/* mc_if.sv */
interface mc_if import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
);

    logic            kick;   // one cycle start pulse, only while ready.
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [1:0]      mode;   // unit specific variant bits.
    logic            ready;
    logic [XLEN-1:0] result; // valid while ready is high.

    modport master (
        output kick, a, b, mode,
        input  ready, result
    );

    modport unit (
        input  kick, a, b, mode,
        output ready, result
    );

endinterface

/* exec_pkg.sv */
package exec_pkg;

    parameter int XLEN_DEF = 32;

    // codes 7 to 15 are not assigned and report an unknown operation.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6
    } alu_op_e;

    // code 3 is not assigned.
    typedef enum logic [1:0] {
        DIV_NOP = 2'd0,
        DIV_DIV = 2'd1,
        DIV_REM = 2'd2
    } div_op_e;

    typedef enum logic [1:0] {
        SH_NOP = 2'd0,
        SH_SLL = 2'd1,
        SH_SRL = 2'd2,
        SH_SRA = 2'd3
    } shift_op_e;

endpackage
